/* src.f */
tcm_pkg.sv
sim_ram.sv
tcm_bank_select.sv
axil_ram_port.sv
tcm_top.sv
tb_tcm_top.sv

/* Makefile */
# Verilator flow for the TCM subsystem

TOP   := tb_tcm_top
BUILD := obj_dir
LOG   := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module tcm_top
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb_tcm_top.sv */
`default_nettype none

module tb_tcm_top import tcm_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TXN  = 400;                // Random operations
    localparam int MAX_WAIT = 50;                 // Cycles per handshake before giving up

    // Memory map at the DUT defaults
    localparam logic [ADDR_W-1:0] ITCM_LO = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] ITCM_HI = 32'h0000_0800; // 512 words
    localparam logic [ADDR_W-1:0] DTCM_LO = 32'h0001_0000;
    localparam logic [ADDR_W-1:0] DTCM_HI = 32'h0001_0400; // 256 words

    logic     clk = 1'b0;
    logic     rst;
    axil_aw_t aw;
    logic     aw_valid;
    logic     aw_ready;
    axil_w_t  w;
    logic     w_valid;
    logic     w_ready;
    axil_b_t  b;
    logic     b_valid;
    logic     b_ready;
    axil_ar_t ar;
    logic     ar_valid;
    logic     ar_ready;
    axil_r_t  r;
    logic     r_valid;
    logic     r_ready;

    logic [31:0] seed = 32'hd93b932b;
    bit [7:0]    model [bit [ADDR_W-1:0]];        // Byte-wide reference memory
    int          mismatch_count = 0;
    int          fail_count = 0;

    tcm_top u_tcm_top (
        .clk     (clk),
        .rst     (rst),
        .aw      (aw),
        .aw_valid(aw_valid),
        .aw_ready(aw_ready),
        .w       (w),
        .w_valid (w_valid),
        .w_ready (w_ready),
        .b       (b),
        .b_valid (b_valid),
        .b_ready (b_ready),
        .ar      (ar),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .r       (r),
        .r_valid (r_valid),
        .r_ready (r_ready)
    );

    always #2 clk = ~clk;                         // 4 ns period

    // ==================================================
    // Random source and reference model
    // ==================================================
    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic bit in_window(input logic [ADDR_W-1:0] a);
        return ((a >= ITCM_LO) && (a < ITCM_HI)) || ((a >= DTCM_LO) && (a < DTCM_HI));
    endfunction

    function automatic logic [DATA_W-1:0] model_word(input logic [ADDR_W-1:0] a);
        logic [DATA_W-1:0] word;
        word = '0;                                // Unwritten bytes read as zero
        for (int i = 0; i < STRB_W; i++) begin
            if (model.exists(a + 32'(i))) begin
                word[8*i +: 8] = model[a + 32'(i)];
            end
        end
        return word;
    endfunction

    function automatic void model_write(input logic [ADDR_W-1:0] a,
                                        input logic [DATA_W-1:0] d,
                                        input logic [STRB_W-1:0] strb);
        if (in_window(a)) begin                   // Misses leave memory untouched
            for (int i = 0; i < STRB_W; i++) begin
                if (strb[i]) begin
                    model[a + 32'(i)] = d[8*i +: 8];
                end
            end
        end
    endfunction

    function automatic logic [ADDR_W-1:0] pick_addr();
        logic [31:0]       rnd;
        logic [31:0]       idx;
        logic [ADDR_W-1:0] a;
        rnd = lcg();
        idx = rnd[31] ? {23'd0, rnd[24:16]} : {27'd0, rnd[20:16]}; // Whole bank or hot set
        case (rnd[30:28])
            3'd0: begin                           // Miss about 1 in 8 times
                case (rnd[27:26])
                    2'd0:    a = ITCM_HI;         // Just past ITCM
                    2'd1:    a = DTCM_HI;         // Just past DTCM
                    2'd2:    a = DTCM_LO - 32'd4; // Top of the gap
                    default: a = 32'h0000_8000 + (idx << 2);
                endcase
            end
            3'd1, 3'd2, 3'd3: a = ITCM_LO + ((idx % 512) << 2);
            default:          a = DTCM_LO + ((idx % 256) << 2);
        endcase
        return a;
    endfunction

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic check_b(input axil_b_t exp, input axil_b_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: b resp expected %0h got %0h", $time, exp.resp, act.resp);
        end
    endtask

    task automatic check_r(input axil_r_t exp, input axil_r_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: r expected data %h resp %0h got data %h resp %0h",
                     $time, exp.data, exp.resp, act.data, act.resp);
        end
    endtask

    task automatic check_reset_idle();
        logic [4:0] act;
        act = {aw_ready, w_ready, ar_ready, b_valid, r_valid};
        if (act !== 5'b0) begin
            mismatch_count++;
            $display("mismatch at %0t: readies and valids expected 00000 got %b", $time, act);
        end
    endtask

    task automatic check_latency(input int exp, input int act);
        if (act != exp) begin
            mismatch_count++;
            $display("mismatch at %0t: response latency expected %0d got %0d", $time, exp, act);
        end
    endtask

    task automatic protocol_fail(input string msg);
        fail_count++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // ==================================================
    // Bus handshakes
    // ==================================================
    task automatic step();
        @(posedge clk);
        #0.5;                                     // Drive just after the edge
    endtask

    task automatic wait_accept(input bit wr);
        int n;
        n = 0;
        @(negedge clk);
        while (!(wr ? (aw_ready && w_ready) : ar_ready) && n < MAX_WAIT) begin
            n++;
            @(negedge clk);
        end
        if (n >= MAX_WAIT) begin
            protocol_fail(wr ? "write was never accepted" : "read was never accepted");
        end else if (wr && ar_valid && ar_ready) begin
            protocol_fail("ar_ready was high in the cycle a write was accepted");
        end
        step();                                   // Transfer edge passed
    endtask

    task automatic wait_resp(input bit is_read, input axil_b_t exp_b, input axil_r_t exp_r);
        bit seen;
        bit done;
        int n;
        seen = 1'b0;
        done = 1'b0;
        n    = 0;
        while (!done) begin
            @(negedge clk);
            n++;                                  // Cycles since the transfer edge
            if ((aw_ready | w_ready | ar_ready) !== 1'b0) begin
                protocol_fail("a ready was high while a response was pending");
            end
            if (is_read ? r_valid : b_valid) begin
                if (!seen) begin
                    check_latency(is_read ? 2 : 1, n);
                end
                seen = 1'b1;
                if (is_read) begin
                    check_r(exp_r, r);            // Compared every held cycle for stability
                end else begin
                    check_b(exp_b, b);
                end
                done = is_read ? r_ready : b_ready;
            end else if (seen) begin
                protocol_fail("response valid dropped before its ready");
                done = 1'b1;
            end else if (n > MAX_WAIT) begin
                protocol_fail("response valid never rose");
                done = 1'b1;
            end
            step();
            b_ready = lcg() >= 32'h4000_0000;     // Low about a quarter of cycles
            r_ready = lcg() >= 32'h4000_0000;
        end
    endtask

    // Write, read, or both at once to one address
    task automatic access(input bit wr, input bit rd, input logic [ADDR_W-1:0] a);
        axil_b_t exp_b;
        axil_r_t exp_r;
        exp_b    = '0;
        exp_r    = '0;
        aw.addr  = a;
        aw.prot  = 3'(lcg());
        ar.addr  = a;
        ar.prot  = 3'(lcg());
        w.data   = lcg();
        w.strb   = 4'(lcg() >> 28);               // Any mask, empty included
        aw_valid = wr;
        w_valid  = wr;
        ar_valid = rd;
        if (wr) begin
            wait_accept(1'b1);
            aw_valid   = 1'b0;
            w_valid    = 1'b0;
            exp_b.resp = in_window(a) ? RESP_OKAY : RESP_SLVERR;
            model_write(a, w.data, w.strb);
            wait_resp(1'b0, exp_b, exp_r);
        end
        if (rd) begin
            wait_accept(1'b0);                    // AR held through any write
            ar_valid   = 1'b0;
            exp_r.data = in_window(a) ? model_word(a) : '0;
            exp_r.resp = in_window(a) ? RESP_OKAY : RESP_SLVERR;
            wait_resp(1'b1, exp_b, exp_r);
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        logic [2:0]        op;
        logic [ADDR_W-1:0] a;
        rst      = 1'b1;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b1;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b1;
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #0.5;
            if (i == 2) begin
                rst = 1'b0;                       // Three reset edges
            end
            @(negedge clk);
            check_reset_idle();                   // Last pass is the first cycle out
        end
        step();
        for (int t = 0; t < NUM_TXN; t++) begin
            op = 3'(lcg() >> 29);
            a  = pick_addr();
            case (op)
                3'd0, 3'd1, 3'd2: access(1'b1, 1'b0, a);
                3'd3, 3'd4, 3'd5: access(1'b0, 1'b1, a);
                3'd6:             access(1'b1, 1'b1, a); // Same-cycle AW/W and AR
                default: begin
                    access(1'b1, 1'b0, a);        // Write then read back
                    access(1'b0, 1'b1, a);
                end
            endcase
        end
        $display("errors: %0d mismatches, %0d protocol failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog allows 20 cycles per operation plus margin
    initial begin
        #((NUM_TXN * 20 + 200) * 4);
        $display("watchdog expired before all operations completed");
        $display("errors: %0d mismatches, %0d protocol failures", mismatch_count, fail_count);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tcm_top.sv */
`default_nettype none

module tcm_top import tcm_pkg::*; #(
    parameter logic [ADDR_W-1:0] ITCM_BASE  = 32'h0000_0000,
    parameter int                ITCM_DEPTH = 512,         // Words
    parameter logic [ADDR_W-1:0] DTCM_BASE  = 32'h0001_0000,
    parameter int                DTCM_DEPTH = 256          // Words
) (
    input  logic     clk,
    input  logic     rst,
    input  axil_aw_t aw,
    input  logic     aw_valid,
    output logic     aw_ready,
    input  axil_w_t  w,
    input  logic     w_valid,
    output logic     w_ready,
    output axil_b_t  b,
    output logic     b_valid,
    input  logic     b_ready,
    input  axil_ar_t ar,
    input  logic     ar_valid,
    output logic     ar_ready,
    output axil_r_t  r,
    output logic     r_valid,
    input  logic     r_ready
);

    localparam int ITCM_AW = $clog2(ITCM_DEPTH);
    localparam int DTCM_AW = $clog2(DTCM_DEPTH);

    // ==================================================
    // Internal nets
    // ==================================================
    ram_req_t          req;
    logic              req_valid;
    logic              hit_err;
    logic [DATA_W-1:0] rdata;
    logic              rd_err;

    logic [ITCM_AW-1:0] itcm_addr;
    logic [DATA_W-1:0]  itcm_din;
    logic               itcm_we;
    logic [STRB_W-1:0]  itcm_wem;
    logic [DATA_W-1:0]  itcm_dout;

    logic [DTCM_AW-1:0] dtcm_addr;
    logic [DATA_W-1:0]  dtcm_din;
    logic               dtcm_we;
    logic [STRB_W-1:0]  dtcm_wem;
    logic [DATA_W-1:0]  dtcm_dout;

    axil_ram_port u_port (
        .clk      (clk),
        .rst      (rst),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .req      (req),
        .req_valid(req_valid),
        .hit_err  (hit_err),
        .rdata    (rdata),
        .rd_err   (rd_err)
    );

    tcm_bank_select #(
        .ITCM_BASE (ITCM_BASE),
        .ITCM_DEPTH(ITCM_DEPTH),
        .DTCM_BASE (DTCM_BASE),
        .DTCM_DEPTH(DTCM_DEPTH)
    ) u_sel (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_valid(req_valid),
        .hit_err  (hit_err),
        .rdata    (rdata),
        .rd_err   (rd_err),
        .itcm_addr(itcm_addr),
        .itcm_din (itcm_din),
        .itcm_we  (itcm_we),
        .itcm_wem (itcm_wem),
        .itcm_dout(itcm_dout),
        .dtcm_addr(dtcm_addr),
        .dtcm_din (dtcm_din),
        .dtcm_we  (dtcm_we),
        .dtcm_wem (dtcm_wem),
        .dtcm_dout(dtcm_dout)
    );

    // Instruction and data arrays
    sim_ram #(.DEPTH(ITCM_DEPTH)) u_itcm (
        .clk (clk),
        .addr(itcm_addr),
        .din (itcm_din),
        .we  (itcm_we),
        .wem (itcm_wem),
        .dout(itcm_dout)
    );

    sim_ram #(.DEPTH(DTCM_DEPTH)) u_dtcm (
        .clk (clk),
        .addr(dtcm_addr),
        .din (dtcm_din),
        .we  (dtcm_we),
        .wem (dtcm_wem),
        .dout(dtcm_dout)
    );

endmodule

`default_nettype wire

/* axil_ram_port.sv */
`default_nettype none

module axil_ram_port import tcm_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // Write address
    input  axil_aw_t          aw,
    input  logic              aw_valid,
    output logic              aw_ready,
    // Write data
    input  axil_w_t           w,
    input  logic              w_valid,
    output logic              w_ready,
    // Write response
    output axil_b_t           b,
    output logic              b_valid,
    input  logic              b_ready,
    // Read address
    input  axil_ar_t          ar,
    input  logic              ar_valid,
    output logic              ar_ready,
    // Read data
    output axil_r_t           r,
    output logic              r_valid,
    input  logic              r_ready,
    // RAM request bus
    output ram_req_t          req,
    output logic              req_valid,
    input  logic              hit_err,
    input  logic [DATA_W-1:0] rdata,
    input  logic              rd_err
);

    typedef enum logic [1:0] {IDLE, READ_WAIT, B_HOLD, R_HOLD} state_t;

    state_t state;
    logic   init_done;                            // Low for one cycle after reset
    logic   ready_en;                             // Free to accept
    logic   wr_pair;                              // AW and W both offered
    logic   wr_go;                                // Write accepted this cycle
    logic   rd_go;                                // Read accepted this cycle

    // ==================================================
    // Accept logic
    // ==================================================
    assign ready_en = init_done && (state == IDLE);
    assign wr_pair  = aw_valid && w_valid;
    assign wr_go    = ready_en && wr_pair;
    assign rd_go    = ready_en && ar_valid && !wr_pair; // Writes win

    assign aw_ready = ready_en && wr_pair;        // AW and W rise together
    assign w_ready  = ready_en && wr_pair;
    assign ar_ready = ready_en && !wr_pair;

    // Request formed straight from the channel payload
    always_comb begin
        req.addr  = wr_go ? aw.addr : ar.addr;
        req.wdata = w.data;
        req.mask  = wr_go ? w.strb : '0;          // Empty mask on reads
        req.write = wr_go;
    end

    assign req_valid = wr_go || rd_go;

    // ==================================================
    // Transaction FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            init_done <= 1'b0;
        end else begin
            init_done <= 1'b1;
            case (state)
                IDLE: begin
                    if (wr_go) begin
                        state <= B_HOLD;          // RAM written on this edge
                    end else if (rd_go) begin
                        state <= READ_WAIT;       // RAM latches the address
                    end
                end
                READ_WAIT: begin
                    state <= R_HOLD;              // Data captured below
                end
                B_HOLD: begin
                    if (b_ready) begin
                        state <= IDLE;
                    end
                end
                R_HOLD: begin
                    if (r_ready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ==================================================
    // Response registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (wr_go) begin
            b.resp <= hit_err ? RESP_SLVERR : RESP_OKAY;
        end
        if (state == READ_WAIT) begin
            r.data <= rdata;                      // Zero on a decode miss
            r.resp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    assign b_valid = (state == B_HOLD);           // Held until b_ready
    assign r_valid = (state == R_HOLD);           // Held until r_ready

endmodule

`default_nettype wire

/* tcm_bank_select.sv */
`default_nettype none

module tcm_bank_select import tcm_pkg::*; #(
    parameter logic [ADDR_W-1:0] ITCM_BASE  = 32'h0000_0000,
    parameter int                ITCM_DEPTH = 512,
    parameter logic [ADDR_W-1:0] DTCM_BASE  = 32'h0001_0000,
    parameter int                DTCM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    input  ram_req_t                      req,
    input  logic                          req_valid,
    output logic                          hit_err,
    output logic [DATA_W-1:0]             rdata,
    output logic                          rd_err,
    output logic [$clog2(ITCM_DEPTH)-1:0] itcm_addr,
    output logic [DATA_W-1:0]             itcm_din,
    output logic                          itcm_we,
    output logic [STRB_W-1:0]             itcm_wem,
    input  logic [DATA_W-1:0]             itcm_dout,
    output logic [$clog2(DTCM_DEPTH)-1:0] dtcm_addr,
    output logic [DATA_W-1:0]             dtcm_din,
    output logic                          dtcm_we,
    output logic [STRB_W-1:0]             dtcm_wem,
    input  logic [DATA_W-1:0]             dtcm_dout
);

    localparam int LSB     = $clog2(STRB_W);      // Byte offset bits
    localparam int ITCM_AW = $clog2(ITCM_DEPTH);
    localparam int DTCM_AW = $clog2(DTCM_DEPTH);

    localparam logic [ADDR_W-1:0] ITCM_END = ITCM_BASE + ADDR_W'(ITCM_DEPTH * STRB_W);
    localparam logic [ADDR_W-1:0] DTCM_END = DTCM_BASE + ADDR_W'(DTCM_DEPTH * STRB_W);

    typedef enum logic [1:0] {SEL_NONE, SEL_ITCM, SEL_DTCM} sel_t;

    logic              itcm_hit;
    logic              dtcm_hit;
    logic [ADDR_W-1:0] itcm_off;                  // Offset into ITCM window
    logic [ADDR_W-1:0] dtcm_off;                  // Offset into DTCM window
    sel_t              sel_q;                     // Bank of the last read

    // ==================================================
    // Address decode
    // ==================================================
    assign itcm_hit = (req.addr >= ITCM_BASE) && (req.addr < ITCM_END);
    assign dtcm_hit = (req.addr >= DTCM_BASE) && (req.addr < DTCM_END);
    assign hit_err  = !itcm_hit && !dtcm_hit;     // Neither window

    assign itcm_off = req.addr - ITCM_BASE;
    assign dtcm_off = req.addr - DTCM_BASE;

    // Request steering
    assign itcm_addr = itcm_off[LSB +: ITCM_AW];  // Word index
    assign itcm_din  = req.wdata;
    assign itcm_wem  = req.mask;
    assign itcm_we   = req_valid && req.write && itcm_hit; // Hit bank only

    assign dtcm_addr = dtcm_off[LSB +: DTCM_AW];
    assign dtcm_din  = req.wdata;
    assign dtcm_wem  = req.mask;
    assign dtcm_we   = req_valid && req.write && dtcm_hit;

    // ==================================================
    // Read return path
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= SEL_NONE;
        end else if (req_valid && !req.write) begin
            if (itcm_hit) begin
                sel_q <= SEL_ITCM;
            end else if (dtcm_hit) begin
                sel_q <= SEL_DTCM;
            end else begin
                sel_q <= SEL_NONE;                // Decode miss
            end
        end
    end

    always_comb begin
        case (sel_q)
            SEL_ITCM: rdata = itcm_dout;
            SEL_DTCM: rdata = dtcm_dout;
            default:  rdata = '0;                 // Miss reads as zero
        endcase
    end

    assign rd_err = (sel_q == SEL_NONE);

endmodule

`default_nettype wire

/* sim_ram.sv */
`default_nettype none

module sim_ram import tcm_pkg::*; #(
    parameter int DEPTH = 512                     // Word count as a power of two
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,        // Word index
    input  logic [DATA_W-1:0]        din,
    input  logic                     we,
    input  logic [STRB_W-1:0]        wem,         // Byte write mask
    output logic [DATA_W-1:0]        dout
);

    localparam int AW = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];               // Storage array
    logic [AW-1:0]     addr_r;                    // Registered read address

    // ==================================================
    // Byte-lane write port
    // ==================================================
    always @(posedge clk) begin
        for (int i = 0; i < STRB_W; i++) begin
            if (we && wem[i]) begin
                mem[addr][8*i +: 8] <= din[8*i +: 8]; // Only masked lanes change
            end
        end
    end

    // Read address loads on any non-write cycle
    always_ff @(posedge clk) begin
        if (!we) begin
            addr_r <= addr;
        end
    end

    assign dout = mem[addr_r];                    // Holds while addr_r is stable

    // Start from a zeroed array
    initial begin
        for (int k = 0; k < DEPTH; k++) begin
            mem[k] = '0;
        end
    end

endmodule

`default_nettype wire

/* tcm_pkg.sv */
`default_nettype none

package tcm_pkg;

    // ==================================================
    // Widths
    // ==================================================
    localparam int ADDR_W = 32;                   // Byte address
    localparam int DATA_W = 32;                   // One word per beat
    localparam int STRB_W = DATA_W / 8;           // Byte lanes

    // ==================================================
    // Response codes
    // ==================================================
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;        // Normal access
    localparam resp_t RESP_SLVERR = 2'b10;        // Address outside both TCMs

    // ==================================================
    // AXI4-Lite channel payloads
    // ==================================================
    typedef struct packed {
        logic [ADDR_W-1:0] addr;                  // Byte address
        logic [2:0]        prot;                  // Not used by the TCM
    } axil_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;                  // One bit per byte lane
    } axil_w_t;

    typedef struct packed {
        resp_t resp;
    } axil_b_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [2:0]        prot;                  // Not used by the TCM
    } axil_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        resp_t             resp;
    } axil_r_t;

    // Internal single-port RAM request
    typedef struct packed {
        logic [ADDR_W-1:0] addr;                  // Byte address not yet decoded
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] mask;                  // Zero on reads
        logic              write;                 // Low for a read
    } ram_req_t;

endpackage

`default_nettype wire
